// File: all.f
hw/text_pkg.sv
hw/tile_wr_if.sv
hw/cursor_ctrl.sv
hw/tile_ram.sv
hw/glyph_fetch.sv
hw/pixel_mux.sv
hw/text_screen.sv
tb/tb_text_screen.sv

// File: hw/cursor_ctrl.sv
// cursor controller: runs four-phase req/ack commands, moves the cursor, writes tiles
`default_nettype none
`timescale 1ns/1ps

module cursor_ctrl
   import text_pkg::*;
(
   input  wire               clk,
   input  wire               arst_n,
   input  wire               cmd_req,
   input  var cmd_op_t       cmd_op,
   input  wire  [code_w-1:0] cmd_data,
   output logic              cmd_ack,
   tile_wr_if.writer         wr
);

   typedef enum logic {
      st_idle,
      st_done
   } state_t;

   state_t            state;
   logic              accept;
   logic              move_pend;
   logic              wr_en_q;
   cmd_op_t           op_q;
   logic [code_w-1:0] code_q;
   logic [col_w-1:0]  cur_col;
   logic [row_w-1:0]  cur_row;

   assign accept = (state == st_idle) && cmd_req;

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state     <= st_idle;
         move_pend <= 1'b0;
         wr_en_q   <= 1'b0;
         cur_col   <= '0;
         cur_row   <= '0;
      end
      else
      begin
         wr_en_q   <= 1'b0;
         move_pend <= 1'b0;
         case (state)
            st_idle:
            begin
               if (cmd_req)
               begin
                  state     <= st_done;
                  move_pend <= 1'b1;
                  // put writes at the old position, ack rises together
                  wr_en_q   <= (cmd_op == op_put);
               end
            end
            st_done:
            begin
               if (!cmd_req)
                  state <= st_idle;
            end
            default:
               state <= st_idle;
         endcase
         // cursor moves one cycle after the accept
         if (move_pend)
         begin
            case (op_q)
               op_put, op_right:
                  cur_col <= (cur_col == col_w'(tile_cols - 1)) ? '0 : cur_col + 1'b1;
               op_down:
                  cur_row <= (cur_row == row_w'(tile_rows - 1)) ? '0 : cur_row + 1'b1;
               op_home:
               begin
                  cur_col <= '0;
                  cur_row <= '0;
               end
            endcase
         end
      end
   end

   // command payload, held for the move and the write
   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         op_q   <= cmd_op;
         code_q <= cmd_data;
      end
   end

   assign cmd_ack  = (state == st_done);
   assign wr.col   = cur_col;
   assign wr.row   = cur_row;
   assign wr.wr_en = wr_en_q;
   assign wr.code  = code_q;

   a_ack_after_req: assert property (@(posedge clk) disable iff (!arst_n)
      $rose(cmd_ack) |-> $past(cmd_req));

   a_cursor_range: assert property (@(posedge clk) disable iff (!arst_n)
      (int'(cur_col) < tile_cols) && (int'(cur_row) < tile_rows));

endmodule

`default_nettype wire

// File: hw/glyph_fetch.sv
// glyph fetch: pixel coordinate to tile code to font row, two register stages
`default_nettype none
`timescale 1ns/1ps

module glyph_fetch
   import text_pkg::*;
(
   input  wire                clk,
   input  wire                arst_n,
   tile_wr_if.store           wr,
   input  wire  [coord_w-1:0] pixel_x,
   input  wire  [coord_w-1:0] pixel_y,
   input  wire                video_on,
   output logic               font_bit,
   output logic [col_w-1:0]   tile_col_d,
   output logic [row_w-1:0]   tile_row_d,
   output logic               video_on_d
);

   logic [col_w-1:0]     tile_col;
   logic [row_w-1:0]     tile_row;
   logic [code_w-1:0]    rd_code;

   // stage 1, alongside the tile memory read
   logic [glyph_w-1:0]   glyph_row_1;
   logic [glyph_w-1:0]   bit_idx_1;
   logic [col_w-1:0]     col_1;
   logic [row_w-1:0]     row_1;
   logic                 von_1;

   // stage 2, font row register
   logic [2*glyph_w-1:0] row_lsb;
   logic [tile_px-1:0]   glyph_byte;
   logic [tile_px-1:0]   font_row_2;
   logic [glyph_w-1:0]   bit_idx_2;
   logic [col_w-1:0]     col_2;
   logic [row_w-1:0]     row_2;
   logic                 von_2;

   assign tile_col = pixel_x[glyph_w +: col_w];
   assign tile_row = pixel_y[glyph_w +: row_w];

   tile_ram i_tile_ram (
      .clk     (clk),
      .wr      (wr),
      .rd_col  (tile_col),
      .rd_row  (tile_row),
      .rd_code (rd_code)
   );

   // glyph row 0 sits in the top byte of the entry
   assign row_lsb    = {~glyph_row_1, 3'b000};
   assign glyph_byte = font_table[rd_code][row_lsb +: tile_px];

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         von_1 <= 1'b0;
         von_2 <= 1'b0;
      end
      else
      begin
         von_1 <= video_on;
         von_2 <= von_1;
      end
   end

   always_ff @(posedge clk)
   begin
      glyph_row_1 <= pixel_y[glyph_w-1:0];
      bit_idx_1   <= pixel_x[glyph_w-1:0];
      col_1       <= tile_col;
      row_1       <= tile_row;
      font_row_2  <= glyph_byte;
      bit_idx_2   <= bit_idx_1;
      col_2       <= col_1;
      row_2       <= row_1;
   end

   // msb of the row byte is the leftmost pixel
   assign font_bit   = font_row_2[~bit_idx_2];
   assign tile_col_d = col_2;
   assign tile_row_d = row_2;
   assign video_on_d = von_2;

endmodule

`default_nettype wire

// File: hw/pixel_mux.sv
// pixel combiner: cursor reverse video, blanking and the rgb output register
`default_nettype none
`timescale 1ns/1ps

module pixel_mux
   import text_pkg::*;
(
   input  wire               clk,
   input  wire               arst_n,
   tile_wr_if.viewer         cur,
   input  wire               font_bit,
   input  wire  [col_w-1:0]  tile_col_d,
   input  wire  [row_w-1:0]  tile_row_d,
   input  wire               video_on_d,
   output logic [rgb_w-1:0]  text_rgb
);

   logic cursor_on;
   logic lit;

   // live cursor position against the delayed tile
   assign cursor_on = (tile_col_d == cur.col) && (tile_row_d == cur.row);
   assign lit       = font_bit ^ cursor_on;

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         text_rgb <= '0;
      else if (!video_on_d)
         // blank outside the visible area
         text_rgb <= '0;
      else
         text_rgb <= lit ? fg_rgb : bg_rgb;
   end

endmodule

`default_nettype wire

// File: hw/text_pkg.sv
// text screen package: screen geometry, command opcodes and the hex digit font
`default_nettype none

package text_pkg;

   // 640x480 raster split into 8x8 tiles
   localparam int coord_w = 10;
   localparam int glyph_w = 3;
   localparam int tile_px = 8;
   localparam int tile_cols = 80;
   localparam int tile_rows = 60;
   localparam int col_w = 7;
   localparam int row_w = 6;
   localparam int code_w = 4;

   // green text on black
   localparam int rgb_w = 3;
   localparam logic [rgb_w-1:0] fg_rgb = 3'b010;
   localparam logic [rgb_w-1:0] bg_rgb = 3'b000;

   typedef enum logic [1:0] {
      op_put,
      op_right,
      op_down,
      op_home
   } cmd_op_t;

   // one glyph per code, row 0 in the top byte, msb is the leftmost pixel
   localparam logic [63:0] font_table [16] = '{
      // digits 0 to 7
      64'h3C666E7666663C00,
      64'h1838181818187E00,
      64'h3C66060C30607E00,
      64'h3C66061C06663C00,
      64'h0C1C3C6C7E0C0C00,
      64'h7E607C0606663C00,
      64'h3C607C6666663C00,
      64'h7E060C1830303000,
      // digits 8 and 9, then A to F
      64'h3C66663C66663C00,
      64'h3C66663E060C3800,
      64'h183C66667E666600,
      64'h7C66667C66667C00,
      64'h3C66606060663C00,
      64'h786C6666666C7800,
      64'h7E60607C60607E00,
      64'h7E60607C60606000
   };

endpackage

`default_nettype wire

// File: hw/text_screen.sv
// text screen top: command side, pixel pipeline and combiner wired together
`default_nettype none
`timescale 1ns/1ps

module text_screen
   import text_pkg::*;
(
   input  wire                clk,
   input  wire                arst_n,
   input  wire                cmd_req,
   input  var cmd_op_t        cmd_op,
   input  wire  [code_w-1:0]  cmd_data,
   output logic               cmd_ack,
   input  wire  [coord_w-1:0] pixel_x,
   input  wire  [coord_w-1:0] pixel_y,
   input  wire                video_on,
   output logic [rgb_w-1:0]   text_rgb
);

   logic             font_bit;
   logic [col_w-1:0] tile_col_d;
   logic [row_w-1:0] tile_row_d;
   logic             video_on_d;

   tile_wr_if i_tile_wr ();

   cursor_ctrl i_cursor_ctrl (
      .clk      (clk),
      .arst_n   (arst_n),
      .cmd_req  (cmd_req),
      .cmd_op   (cmd_op),
      .cmd_data (cmd_data),
      .cmd_ack  (cmd_ack),
      .wr       (i_tile_wr.writer)
   );

   glyph_fetch i_glyph_fetch (
      .clk        (clk),
      .arst_n     (arst_n),
      .wr         (i_tile_wr.store),
      .pixel_x    (pixel_x),
      .pixel_y    (pixel_y),
      .video_on   (video_on),
      .font_bit   (font_bit),
      .tile_col_d (tile_col_d),
      .tile_row_d (tile_row_d),
      .video_on_d (video_on_d)
   );

   pixel_mux i_pixel_mux (
      .clk        (clk),
      .arst_n     (arst_n),
      .cur        (i_tile_wr.viewer),
      .font_bit   (font_bit),
      .tile_col_d (tile_col_d),
      .tile_row_d (tile_row_d),
      .video_on_d (video_on_d),
      .text_rgb   (text_rgb)
   );

endmodule

`default_nettype wire

// File: hw/tile_ram.sv
// tile memory: one write port from the cursor side, one registered read port
`default_nettype none
`timescale 1ns/1ps

module tile_ram
   import text_pkg::*;
(
   input  wire               clk,
   tile_wr_if.store          wr,
   input  wire  [col_w-1:0]  rd_col,
   input  wire  [row_w-1:0]  rd_row,
   output logic [code_w-1:0] rd_code
);

   // addressed by {row, col}, so some words are never used
   logic [code_w-1:0] mem [1 << (row_w + col_w)];

   // read during write to the same word returns the old code
   always_ff @(posedge clk)
   begin
      if (wr.wr_en)
         mem[{wr.row, wr.col}] <= wr.code;
      rd_code <= mem[{rd_row, rd_col}];
   end

   a_wr_row_range: assert property (@(posedge clk)
      wr.wr_en |-> (int'(wr.row) < tile_rows));

endmodule

`default_nettype wire

// File: hw/tile_wr_if.sv
// tile write interface: cursor position plus tile write strobe and code
`default_nettype none
`timescale 1ns/1ps

interface tile_wr_if
   import text_pkg::*;
   ();

   logic [col_w-1:0]  col;
   logic [row_w-1:0]  row;
   logic              wr_en;
   logic [code_w-1:0] code;

   // command side owns the cursor and the write
   modport writer (output col, output row, output wr_en, output code);
   modport store  (input wr_en, input col, input row, input code);
   // combiner only needs the position
   modport viewer (input col, input row);

endinterface

`default_nettype wire

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --assert -sv --top-module tb_text_screen -f all.f &&
./obj_dir/Vtb_text_screen || exit 1

// File: tb/screen_cases.txt
// command: 0_nnn_000_o_d  repeat count nnn, opcode o (0 put, 1 right, 2 down, 3 home), data d
// probe:   1_xxx_yyy_v_r  pixel x, pixel y, video_on v, expected rgb r; f_... ends the list
// digits 1, 2, 3 on tiles 0..2 of row 0, cursor ends on tile 3
0_001_000_0_1
0_001_000_0_2
0_001_000_0_3
1_003_000_1_2
1_000_000_1_0
1_009_001_1_2
1_008_001_1_0
1_013_003_1_2
1_010_003_1_0
// cursor on tile 1 inverts it, moving on restores it
0_001_000_3_0
0_001_000_1_0
1_009_001_1_0
1_008_001_1_2
0_001_000_1_0
1_009_001_1_2
// 80 rights and 60 downs come back to tile 2
0_050_000_1_0
1_010_003_1_2
0_03c_000_2_0
1_013_003_1_0
1_010_003_1_2
// blanked even where the cursor makes it lit
1_010_003_0_0
// home, then A replaces the 1 on tile 0
0_001_000_3_0
0_001_000_0_a
1_001_002_1_2
1_003_002_1_0
1_009_001_1_0
f_000_000_0_0

// File: tb/tb_text_screen.sv
// text screen testbench: runs commands and pixel probes from the cases file, checks rgb
`default_nettype none
`timescale 1ns/1ps

module tb_text_screen
   import text_pkg::*;
   ();

   localparam int reset_cycles = 10;
   localparam int max_cases = 64;
   localparam int ack_limit = 20;

   logic               clk;
   logic               arst_n;
   logic               cmd_req;
   cmd_op_t            cmd_op;
   logic [code_w-1:0]  cmd_data;
   logic               cmd_ack;
   logic [coord_w-1:0] pixel_x;
   logic [coord_w-1:0] pixel_y;
   logic               video_on;
   logic [rgb_w-1:0]   text_rgb;

   // kind, x or repeat count, y, video_on or opcode, rgb or data
   logic [35:0] cases [max_cases];
   int          cycle_limit = 100000;
   int          cycles = 0;

   text_screen i_text_screen (
      .clk      (clk),
      .arst_n   (arst_n),
      .cmd_req  (cmd_req),
      .cmd_op   (cmd_op),
      .cmd_data (cmd_data),
      .cmd_ack  (cmd_ack),
      .pixel_x  (pixel_x),
      .pixel_y  (pixel_y),
      .video_on (video_on),
      .text_rgb (text_rgb)
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("TESTBENCH FAILED");
      $fatal(1, "run stopped");
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("** Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
         $display("TESTBENCH FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic wait_ack(input logic level);
      int waited;
      waited = 0;
      while (cmd_ack !== level)
      begin
         if (waited == ack_limit)
            fail_run($sformatf("cmd_ack did not go to %0d within %0d cycles", level, ack_limit));
         @(negedge clk);
         waited++;
      end
   endtask

   // full four-phase handshake for one command
   task automatic run_command(input logic [1:0] op, input logic [code_w-1:0] data);
      @(negedge clk);
      cmd_req  = 1'b1;
      cmd_op   = cmd_op_t'(op);
      cmd_data = data;
      @(negedge clk);
      wait_ack(1'b1);
      cmd_req = 1'b0;
      @(negedge clk);
      wait_ack(1'b0);
   endtask

   // one pixel in, rgb checked three cycles after it was driven
   task automatic run_probe(input logic [coord_w-1:0] x, input logic [coord_w-1:0] y,
                            input logic von, input logic [rgb_w-1:0] exp_rgb);
      @(negedge clk);
      pixel_x  = x;
      pixel_y  = y;
      video_on = von;
      @(negedge clk);
      video_on = 1'b0;
      repeat (2) @(negedge clk);
      check_value("text_rgb", 32'(text_rgb), 32'(exp_rgb));
   endtask

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit)
         fail_run($sformatf("timeout, run went past %0d cycles", cycle_limit));
   end

   initial
   begin
      int          n_cases;
      int          steps;
      logic [35:0] entry;
      arst_n   = 1'b0;
      cmd_req  = 1'b0;
      cmd_op   = op_put;
      cmd_data = '0;
      pixel_x  = '0;
      pixel_y  = '0;
      video_on = 1'b0;
      $readmemh("tb/screen_cases.txt", cases);
      n_cases = 0;
      steps   = 0;
      // each repeated command counts as its own step
      while (n_cases < max_cases && cases[n_cases][35:32] != 4'hf)
      begin
         steps += (cases[n_cases][35:32] == 4'h0) ? int'(cases[n_cases][31:20]) : 1;
         n_cases++;
      end
      if (n_cases == max_cases)
         fail_run("cases file has no end marker");
      cycle_limit = reset_cycles + 40 * (steps + 1);
      repeat (reset_cycles) @(negedge clk);
      arst_n = 1'b1;
      @(negedge clk);
      check_value("cmd_ack", 32'(cmd_ack), 32'd0);
      check_value("text_rgb", 32'(text_rgb), 32'd0);
      for (int i = 0; i < n_cases; i++)
      begin
         entry = cases[i];
         if (entry[35:32] == 4'h0)
            repeat (int'(entry[31:20])) run_command(entry[5:4], entry[3:0]);
         else if (entry[35:32] == 4'h1)
            run_probe(entry[29:20], entry[17:8], entry[4], entry[2:0]);
         else
            fail_run($sformatf("unknown case kind on entry %0d", i));
      end
      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule

`default_nettype wire
